// ==== build.f ====
+incdir+include
logic/spi_pkg.sv
logic/spi_peripheral.sv
logic/spi_command_router.sv
logic/device_registers.sv
logic/pwm_generator.sv
logic/spi_subsystem_top.sv
test/spi_subsystem_asserts.sv
test/spi_subsystem_tb.sv

// ==== Makefile ====
# Verilator build and run of the SPI subsystem testbench

SOURCES := build.f $(wildcard include/*.svh logic/*.sv test/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vspi_subsystem_tb: $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal \
		--top-module spi_subsystem_tb -f build.f

run: obj_dir/Vspi_subsystem_tb
	obj_dir/Vspi_subsystem_tb +verilator+error+limit+1000 | tee sim.log
	@if grep -q "Test failed" sim.log; then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "Test completed successfully" sim.log; then \
		echo "simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

// ==== test/spi_subsystem_tb.sv ====
// Testbench for the SPI subsystem top level, runs SPI frames and PWM checks and prints a summary
`timescale 1ns/100ps
`include "spi_defines.svh"

module spi_subsystem_tb;

    // Register map and identity byte
    localparam logic [6:0] identity_address    = 7'h00;
    localparam logic [6:0] scratch_address     = 7'h01;
    localparam logic [6:0] control_address     = 7'h02;
    localparam logic [6:0] duty_address        = 7'h03;
    localparam logic [6:0] write_count_address = 7'h04;
    localparam logic [7:0] identity_value      = 8'h81;

    logic spi_clock;
    logic rst;
    logic spi_select;
    logic spi_data_in;
    logic spi_data_out;
    logic pwm_out;

    // Bytes sent and captured in the data phase of a frame
    logic [7:0] tx_bytes [0:3];
    logic [7:0] rx_bytes [0:3];

    int error_count;
    int errors_before;
    int test_count;
    int failed_tests;
    int expected_writes;

    logic [7:0] value_a;
    logic [7:0] value_b;
    logic [7:0] value_c;
    logic [7:0] duty_value;
    logic [7:0] read_byte;
    int         high_cycles;

    spi_subsystem_top UUT (
        .spi_clock    (spi_clock),
        .rst          (rst),
        .spi_select   (spi_select),
        .spi_data_in  (spi_data_in),
        .spi_data_out (spi_data_out),
        .pwm_out      (pwm_out)
    );

    // 4 ns period
    always #2 spi_clock = ~spi_clock;

    // Address byte with the write flag in place
    function automatic logic [7:0] command_byte(input logic write, input logic [6:0] target);
        logic [7:0] value;
        value = {1'b0, target};
        value[`SPI_WRITE_FLAG_BIT] = write;
        return value;
    endfunction

    // Only scratch, control and duty take writes
    function automatic bit is_writable(input logic [6:0] target);
        return target == scratch_address || target == control_address
            || target == duty_address;
    endfunction

    task automatic check_value(input string what, input int actual, input int expected);
        assert (actual == expected) else begin
            error_count++;
            $display("error at %0d ns: %s is 0x%0h, expected 0x%0h",
                     $time, what, actual, expected);
        end
    endtask

    // Select high, then a short idle gap
    task automatic end_frame();
        @(negedge spi_clock);
        spi_select  = 1'b1;
        spi_data_in = 1'b0;
        repeat (2) @(negedge spi_clock);
    endtask

    task automatic send_address(input logic [7:0] address_byte);
        for (int i = 7; i >= 0; i--) begin
            @(negedge spi_clock);
            spi_select  = 1'b0;
            spi_data_in = address_byte[i];
        end
    endtask

    // Full frame, data_out sampled mid-cycle before the rising edge
    task automatic transfer_frame(input logic [7:0] address_byte, input int byte_count);
        logic [7:0] captured;
        send_address(address_byte);
        for (int n = 0; n < byte_count; n++) begin
            for (int i = 7; i >= 0; i--) begin
                @(negedge spi_clock);
                spi_data_in = tx_bytes[n][i];
                #1;
                captured[i] = spi_data_out;
            end
            rx_bytes[n] = captured;
        end
        end_frame();
    endtask

    // Frame cut short inside the first data byte
    task automatic abort_frame(input logic [7:0] address_byte, input int bit_count);
        send_address(address_byte);
        for (int i = 0; i < bit_count; i++) begin
            @(negedge spi_clock);
            spi_data_in = 1'b1;
        end
        end_frame();
    endtask

    task automatic write_register(input logic [6:0] target, input logic [7:0] value);
        tx_bytes[0] = value;
        transfer_frame(command_byte(1'b1, target), 1);
        if (is_writable(target)) begin
            expected_writes++;
        end
    endtask

    task automatic read_register(input logic [6:0] target, output logic [7:0] value);
        tx_bytes[0] = 8'h00;
        transfer_frame(command_byte(1'b0, target), 1);
        value = rx_bytes[0];
    endtask

    // Bounded wait for the PWM pin
    task automatic wait_pwm_level(input logic level, input int limit);
        int waited;
        waited = 0;
        while (pwm_out !== level && waited < limit) begin
            @(negedge spi_clock);
            waited++;
        end
        if (pwm_out !== level) begin
            $display("timeout: pwm_out did not reach %0b within %0d cycles", level, limit);
            $display("Test failed");
            $finish;
        end
    endtask

    // High cycles over one full PWM period
    task automatic count_pwm_high(output int count);
        count = 0;
        repeat (256) begin
            @(negedge spi_clock);
            if (pwm_out) begin
                count++;
            end
        end
    endtask

    task automatic finish_test(input string name);
        int errors_now;
        errors_now = error_count + UUT.checks.failure_count;
        test_count++;
        if (errors_now == errors_before) begin
            $display("test %0d %s: pass", test_count, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: FAIL with %0d errors", test_count, name,
                     errors_now - errors_before);
        end
        errors_before = errors_now;
    endtask

    initial begin
        spi_clock       = 1'b0;
        rst             = 1'b1;
        spi_select      = 1'b1;
        spi_data_in     = 1'b0;
        error_count     = 0;
        errors_before   = 0;
        test_count      = 0;
        failed_tests    = 0;
        expected_writes = 0;
        void'($urandom(41));

        repeat (4) @(negedge spi_clock);
        rst = 1'b0;

        // Outputs idle after reset
        repeat (16) begin
            @(negedge spi_clock);
            check_value("pwm_out after reset", pwm_out, 0);
            check_value("spi_data_out after reset", spi_data_out, 0);
        end
        finish_test("reset state");

        read_register(identity_address, read_byte);
        check_value("identity", read_byte, identity_value);
        finish_test("identity read");

        value_a = 8'($urandom_range(255, 0));
        value_b = 8'($urandom_range(255, 0));
        value_c = 8'($urandom_range(255, 0));
        write_register(scratch_address, value_a);
        check_value("scratch before first write", rx_bytes[0], 0);
        read_register(scratch_address, read_byte);
        check_value("scratch after write", read_byte, value_a);
        // Second byte shifts out the first byte's value
        tx_bytes[0] = value_b;
        tx_bytes[1] = value_c;
        transfer_frame(command_byte(1'b1, scratch_address), 2);
        expected_writes += 2;
        check_value("scratch byte 0 of two", rx_bytes[0], value_a);
        check_value("scratch byte 1 of two", rx_bytes[1], value_b);
        read_register(scratch_address, read_byte);
        check_value("scratch after two-byte write", read_byte, value_c);
        finish_test("scratch write and read");

        write_register(identity_address, 8'h5a);
        check_value("identity during write", rx_bytes[0], identity_value);
        read_register(identity_address, read_byte);
        check_value("identity after write", read_byte, identity_value);
        read_register(write_count_address, read_byte);
        check_value("write count", read_byte, expected_writes);
        finish_test("identity and write count");

        duty_value = 8'($urandom_range(200, 20));
        write_register(duty_address, duty_value);
        write_register(control_address, 8'h01);
        // Align to the first high cycle of a period
        wait_pwm_level(1'b0, 300);
        wait_pwm_level(1'b1, 300);
        count_pwm_high(high_cycles);
        check_value("pwm high cycles", high_cycles, duty_value);
        // Disable lands about 18 cycles into a high run, so the pin is high when cleared
        write_register(control_address, 8'h00);
        wait_pwm_level(1'b0, 4);
        count_pwm_high(high_cycles);
        check_value("pwm high cycles when disabled", high_cycles, 0);
        finish_test("pwm duty and enable");

        // Five bits of a scratch write, then select rises
        abort_frame(command_byte(1'b1, scratch_address), 5);
        read_register(scratch_address, read_byte);
        check_value("scratch after aborted byte", read_byte, value_c);
        read_register(write_count_address, read_byte);
        check_value("write count after aborted byte", read_byte, expected_writes);
        finish_test("aborted byte");

        $display("%0d tests, %0d passed, %0d failing, %0d check errors in total",
                 test_count, test_count - failed_tests, failed_tests, errors_before);
        if (failed_tests == 0 && errors_before == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== test/spi_subsystem_asserts.sv ====
// Concurrent checks on the SPI subsystem internals, attached to the top level by the bind below
`timescale 1ns/100ps
`include "spi_defines.svh"

module spi_subsystem_asserts (
    input logic                       spi_clock,
    input logic                       rst,
    input logic                       spi_select,
    input logic                       spi_data_out,
    input logic [7:0]                 address,
    input logic                       address_valid,
    input logic                       data_valid,
    input logic                       write_strobe,
    input spi_pkg::register_address_t register_address,
    input logic                       pwm_enable,
    input logic                       pwm_out
);

    // Number of assertion failures, read hierarchically from the testbench
    int failure_count = 0;

    // Goes high with the first accepted write to control
    logic control_written;

    always_ff @(posedge spi_clock) begin
        if (rst) begin
            control_written <= 1'b0;
        end else if (write_strobe && register_address == spi_pkg::reg_control) begin
            control_written <= 1'b1;
        end
    end

    // No PWM activity before control was ever written
    pwm_idle_until_control: assert property (@(posedge spi_clock) disable iff (rst)
        !control_written |-> !pwm_out)
        else begin
            $error("pwm_out high before any write to control");
            failure_count++;
        end

    // Pin low once enable has been clear for two samples
    pwm_off_after_disable: assert property (@(posedge spi_clock) disable iff (rst)
        !pwm_enable && !$past(pwm_enable) |-> !pwm_out)
        else begin
            $error("pwm_out still high after enable cleared");
            failure_count++;
        end

    // Data strobe lasts one cycle
    data_strobe_single: assert property (@(posedge spi_clock) disable iff (rst)
        data_valid |=> !data_valid)
        else begin
            $error("data_valid high for more than one cycle");
            failure_count++;
        end

    // Each data strobe is a write exactly when the held address byte has the write flag
    write_follows_flag: assert property (@(posedge spi_clock) disable iff (rst)
        data_valid |-> write_strobe == address[`SPI_WRITE_FLAG_BIT])
        else begin
            $error("write_strobe does not match the write flag of the frame");
            failure_count++;
        end

    // Line stays quiet until the address byte is held
    quiet_without_address: assert property (@(posedge spi_clock) disable iff (rst)
        !address_valid |-> !spi_data_out)
        else begin
            $error("spi_data_out driven before the address byte was complete");
            failure_count++;
        end

    // Select high ends the frame on the next edge
    frame_ends_on_select: assert property (@(posedge spi_clock) disable iff (rst)
        spi_select |=> !address_valid)
        else begin
            $error("address_valid held after select rose");
            failure_count++;
        end

endmodule

bind spi_subsystem_top spi_subsystem_asserts checks (
    .spi_clock        (spi_clock),
    .rst              (rst),
    .spi_select       (spi_select),
    .spi_data_out     (spi_data_out),
    .address          (address),
    .address_valid    (address_valid),
    .data_valid       (data_valid),
    .write_strobe     (write_strobe),
    .register_address (register_address),
    .pwm_enable       (pwm_enable),
    .pwm_out          (pwm_out)
);

// ==== logic/spi_subsystem_top.sv ====
// Top level of the SPI peripheral controller, connects front end, router, registers and PWM
`timescale 1ns/100ps

module spi_subsystem_top (
    input  logic spi_clock,
    input  logic rst,
    input  logic spi_select,
    input  logic spi_data_in,
    output logic spi_data_out,
    output logic pwm_out
);

    // Front end to router
    logic [7:0]                 address;
    logic                       address_valid;
    logic [7:0]                 data;
    logic                       data_valid;
    logic [7:0]                 read_data;

    // Router to registers
    spi_pkg::register_address_t register_address;
    logic [7:0]                 write_data;
    logic                       write_strobe;
    logic [7:0]                 read_value;

    // Registers to PWM
    logic                       pwm_enable;
    logic [7:0]                 duty;

    // Serial framing and read data shift out
    spi_peripheral front_end (
        .spi_clock     (spi_clock),
        .rst           (rst),
        .spi_select    (spi_select),
        .spi_data_in   (spi_data_in),
        .spi_data_out  (spi_data_out),
        .address       (address),
        .address_valid (address_valid),
        .data          (data),
        .data_valid    (data_valid),
        .read_data     (read_data)
    );

    // Write flag handling and read return
    spi_command_router router (
        .spi_clock        (spi_clock),
        .rst              (rst),
        .address          (address),
        .address_valid    (address_valid),
        .data             (data),
        .data_valid       (data_valid),
        .read_data        (read_data),
        .register_address (register_address),
        .write_data       (write_data),
        .write_strobe     (write_strobe),
        .read_value       (read_value)
    );

    // Identity, scratch, control, duty and write count
    device_registers registers (
        .spi_clock        (spi_clock),
        .rst              (rst),
        .register_address (register_address),
        .write_data       (write_data),
        .write_strobe     (write_strobe),
        .read_value       (read_value),
        .pwm_enable       (pwm_enable),
        .duty             (duty)
    );

    // Output pin
    pwm_generator pwm (
        .spi_clock  (spi_clock),
        .rst        (rst),
        .pwm_enable (pwm_enable),
        .duty       (duty),
        .pwm_out    (pwm_out)
    );

endmodule

// ==== logic/pwm_generator.sv ====
// Single-pin PWM generator, period of 256 cycles with duty and enable from the register block
`timescale 1ns/100ps
`include "spi_defines.svh"

module pwm_generator (
    input  logic       spi_clock,
    input  logic       rst,
    input  logic       pwm_enable,
    input  logic [7:0] duty,
    output logic       pwm_out
);

    // Free-running period counter
    logic [`PWM_COUNTER_WIDTH-1:0] counter;

    // Counter advances every cycle, wraps on its own
    always_ff @(posedge spi_clock) begin
        if (rst) begin
            counter <= '0;
        end else begin
            counter <= counter + 1'b1;
        end
    end

    // Output is high while the counter is below duty
    // Duty 0 never fires, duty 255 leaves a single low cycle
    // Registered so the pin is glitch free
    // Disabling takes effect on the next edge
    always_ff @(posedge spi_clock) begin
        if (rst) begin
            pwm_out <= 1'b0;
        end else begin
            pwm_out <= pwm_enable && (counter < duty);
        end
    end

endmodule

// ==== logic/device_registers.sv ====
// Register block behind the SPI router, holds configuration and drives the PWM settings
`timescale 1ns/100ps
`include "spi_defines.svh"

module device_registers (
    input  logic                       spi_clock,
    input  logic                       rst,

    // Access from the router
    input  spi_pkg::register_address_t register_address,
    input  logic [7:0]                 write_data,
    input  logic                       write_strobe,
    output logic [7:0]                 read_value,

    // PWM configuration
    output logic                       pwm_enable,
    output logic [7:0]                 duty
);

    // Current register contents
    logic [7:0] scratch_value;
    logic [7:0] control_value;
    logic [7:0] duty_value;
    logic [7:0] write_count;

    // Values after this cycle's write, if any
    logic [7:0] scratch_next;
    logic [7:0] control_next;
    logic [7:0] duty_next;
    logic [7:0] write_count_next;

    // Strobe hit a writable register
    logic       write_accepted;

    // Write decode
    // Identity, write count and unmapped addresses drop the write
    always_comb begin
        write_accepted = 1'b0;
        scratch_next   = scratch_value;
        control_next   = control_value;
        duty_next      = duty_value;

        if (write_strobe) begin
            case (register_address)
                spi_pkg::reg_scratch: begin
                    scratch_next   = write_data;
                    write_accepted = 1'b1;
                end
                spi_pkg::reg_control: begin
                    control_next   = write_data;
                    write_accepted = 1'b1;
                end
                spi_pkg::reg_duty: begin
                    duty_next      = write_data;
                    write_accepted = 1'b1;
                end
                default: begin
                    write_accepted = 1'b0;
                end
            endcase
        end

        // Counter of accepted writes, wraps at 255
        write_count_next = write_accepted ? write_count + 8'd1 : write_count;
    end

    // Configuration registers, all cleared by reset
    always_ff @(posedge spi_clock) begin
        if (rst) begin
            scratch_value <= 8'h00;
            control_value <= 8'h00;
            duty_value    <= 8'h00;
            write_count   <= 8'h00;
        end else begin
            scratch_value <= scratch_next;
            control_value <= control_next;
            duty_value    <= duty_next;
            write_count   <= write_count_next;
        end
    end

    // Read decode
    // Uses the post-write values so a byte that starts in the strobe
    // cycle already shifts out the value just written, from its MSB on
    always_comb begin
        case (register_address)
            spi_pkg::reg_identity:    read_value = `SPI_IDENTITY_VALUE;
            spi_pkg::reg_scratch:     read_value = scratch_next;
            spi_pkg::reg_control:     read_value = control_next;
            spi_pkg::reg_duty:        read_value = duty_next;
            spi_pkg::reg_write_count: read_value = write_count;
            default:                  read_value = 8'h00;
        endcase
    end

    // Control bit 0 enables the PWM, other bits are spare
    assign pwm_enable = control_value[0];
    assign duty       = duty_value;

endmodule

// ==== logic/spi_command_router.sv ====
// Command router, turns address and data strobes into register accesses and returns read data
`timescale 1ns/100ps
`include "spi_defines.svh"

module spi_command_router (
    input  logic                      spi_clock,
    input  logic                      rst,

    // From the SPI front end
    input  logic [7:0]                address,
    input  logic                      address_valid,
    input  logic [7:0]                data,
    input  logic                      data_valid,
    output logic [7:0]                read_data,

    // Towards the register block
    output spi_pkg::register_address_t register_address,
    output logic [7:0]                write_data,
    output logic                      write_strobe,
    input  logic [7:0]                read_value
);

    // Write flag of the current frame
    logic write_flag;

    // Flag is captured from the held address byte
    // Cleared between frames so a stale flag never leaks into the next one
    // One cycle of lag is harmless, the first data strobe is 8 cycles away
    always_ff @(posedge spi_clock) begin
        if (rst) begin
            write_flag <= 1'b0;
        end else if (!address_valid) begin
            write_flag <= 1'b0;
        end else begin
            write_flag <= address[`SPI_WRITE_FLAG_BIT];
        end
    end

    // Register select comes straight from the address byte
    // Must be combinational, the first read bit is sent in the
    // same cycle that address_valid rises
    assign register_address = spi_pkg::register_address_t'(address[6:0]);

    // Every data byte of a write frame goes to the same register
    assign write_data = data;

    // Data strobe becomes a write only in a write frame
    // Read frames still strobe, the byte is just a dummy
    assign write_strobe = data_valid && write_flag;

    // Read path back to the front end
    // Zero until the address is known
    assign read_data = address_valid ? read_value : 8'h00;

endmodule

// ==== logic/spi_peripheral.sv ====
// SPI target front end, frames serial bits into address and data strobes for the router
`timescale 1ns/100ps

module spi_peripheral (
    // Serial side
    input  logic       spi_clock,
    input  logic       rst,
    input  logic       spi_select,
    input  logic       spi_data_in,
    output logic       spi_data_out,

    // Strobe side towards the command router
    output logic [7:0] address,
    output logic       address_valid,
    output logic [7:0] data,
    output logic       data_valid,
    input  logic [7:0] read_data
);

    // Frame state and position inside the current byte
    spi_pkg::frame_phase_t phase;
    logic [2:0]            bit_count;

    // First seven bits of the byte in flight, MSB first
    logic [6:0]            shift_reg;

    // Full byte as it stands on the edge that samples bit 7
    logic [7:0]            received_byte;

    assign received_byte = {shift_reg, spi_data_in};

    // Control state
    // Any edge with select high reloads the counter and ends the frame
    always_ff @(posedge spi_clock) begin
        if (rst) begin
            phase         <= spi_pkg::phase_idle;
            bit_count     <= 3'd0;
            address_valid <= 1'b0;
            data_valid    <= 1'b0;
        end else if (spi_select) begin
            // Partial byte is simply dropped here
            phase         <= spi_pkg::phase_idle;
            bit_count     <= 3'd0;
            address_valid <= 1'b0;
            data_valid    <= 1'b0;
        end else begin
            // Strobe lasts a single cycle
            data_valid <= 1'b0;

            // Counter wraps 7 -> 0 so bytes run back to back
            bit_count <= bit_count + 3'd1;

            if (bit_count == 3'd7) begin
                if (phase == spi_pkg::phase_data) begin
                    data_valid <= 1'b1;
                end else begin
                    // Address byte done, held until select rises
                    address_valid <= 1'b1;
                    phase         <= spi_pkg::phase_data;
                end
            end else if (phase == spi_pkg::phase_idle) begin
                // First edge of a new frame samples address bit 7
                phase <= spi_pkg::phase_address;
            end
        end
    end

    // Payload path
    // Shift register and output bytes carry no reset
    always_ff @(posedge spi_clock) begin
        if (!spi_select) begin
            shift_reg <= received_byte[6:0];

            if (bit_count == 3'd7) begin
                if (phase == spi_pkg::phase_data) begin
                    data <= received_byte;
                end else begin
                    address <= received_byte;
                end
            end
        end
    end

    // Read data goes out MSB first, indexed by the bit being sampled
    // Nothing is driven during the address byte or with select high
    assign spi_data_out = (!spi_select && phase == spi_pkg::phase_data)
                        ? read_data[3'd7 - bit_count]
                        : 1'b0;

endmodule

// ==== logic/spi_pkg.sv ====
// Shared types for the SPI subsystem, referenced by scoped name from the RTL
package spi_pkg;

    // Register map seen through the 7-bit address field
    // Addresses not listed here read as zero and drop writes
    typedef enum logic [6:0] {
        reg_identity    = 7'h00,
        reg_scratch     = 7'h01,
        reg_control     = 7'h02,
        reg_duty        = 7'h03,
        reg_write_count = 7'h04
    } register_address_t;

    // Front end frame state
    // phase_idle while select is high
    // phase_address while the address byte shifts in
    // phase_data once the address is held, for all later bytes
    typedef enum logic [1:0] {
        phase_idle    = 2'b00,
        phase_address = 2'b01,
        phase_data    = 2'b10
    } frame_phase_t;

endpackage

// ==== include/spi_defines.svh ====
// Fixed protocol and PWM constants, included by the RTL files that need them
`ifndef SPI_DEFINES_SVH
`define SPI_DEFINES_SVH

// Identity byte returned by the identity register
// Read-only, a write to it is dropped and not counted
`define SPI_IDENTITY_VALUE 8'h81

// Position of the write flag inside the address byte
// Set means every data byte of the frame is written
// The remaining seven bits select the register
`define SPI_WRITE_FLAG_BIT 7

// Width of the free-running PWM counter
// 8 bits gives a 256 cycle period, matching the 8-bit duty register
`define PWM_COUNTER_WIDTH 8

`endif
